// File: build.f
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/alu.sv
logic/regfile.sv
logic/decoder.sv
logic/cpu.sv
tb/tbClock.sv
tb/cpuTb.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv tb/*.sv)

obj_dir/VcpuTb: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module cpuTb -o VcpuTb

.PHONY: run clean

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb
  import isaPkg::*, ctrlPkg::*;
();

  logic        clk;
  logic        reset;
  logic        resetReq;
  logic        loadMem;
  logic        halted;
  logic [15:0] rdata;
  memReq_t     memReq;
  logic [15:0] mem [256];
  logic [15:0] image [256];
  logic [15:0] expMem [256];
  logic [31:0] lfsrState = 32'h80c1;
  int          progPc;
  int          cycleCount = 0;
  int          cycleLimit;
  logic        compareReq;
  logic        compareDone;
  string       testName;

  tbClock clock0 (.resetReq(resetReq), .clk(clk), .reset(reset));

  cpu dut0 (.clk(clk), .reset(reset), .memReq(memReq), .rdata(rdata), .halted(halted));

  // Word memory, combinational read
  assign rdata = mem[memReq.addr[7:0]];

  always @(posedge clk) begin
    if (loadMem) begin
      for (int a = 0; a < 256; a++) begin
        mem[a] <= image[a];
      end
    end else if (memReq.write) begin
      mem[memReq.addr[7:0]] <= memReq.wdata;
    end
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("CHECK FAILED %s expected %04h actual %04h", name, expected, actual));
    end
  endtask

  always @(negedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      failRun($sformatf("Timeout after %0d cycles, the core never halted", cycleCount));
    end else if (!reset && halted && memReq.write) begin
      failRun("The core wrote to memory after it had halted");
    end
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  function automatic logic [15:0] randomBits(input int count);
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[14:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic logic [15:0] aluRef(input logic [15:0] x, input logic [15:0] y,
                                         input logic [2:0] fn);
    case (fn)
      3'd0: return x + y;
      3'd1: return x - y;
      3'd2: return x & y;
      3'd3: return x | y;
      3'd4: return x ^ y;
      3'd5: return ~x;
      3'd6: return x << 1;
      default: return x >> 1;
    endcase
  endfunction

  // Runs the image into expMem, returns instructions executed or -1
  function automatic int isaRun();
    logic [15:0] regs [8];
    logic [15:0] word;
    logic [15:0] result;
    logic [15:0] x;
    logic [15:0] y;
    logic [2:0]  rd;
    for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
    end
    for (int a = 0; a < 256; a++) begin
      expMem[a] = image[a];
    end
    for (int count = 1; count <= 1000; count++) begin
      word = expMem[regs[pcIndex][7:0]];
      rd = word[11:9];
      // Operands see the PC already past this instruction
      regs[pcIndex] = regs[pcIndex] + 16'd1;
      x = regs[word[8:6]];
      y = regs[word[5:3]];
      case (word[15:12])
        opAlu: regs[rd] = aluRef(x, y, word[2:0]);
        opLdi: regs[rd] = {{7{word[8]}}, word[8:0]};
        opLd:  regs[rd] = expMem[x[7:0]];
        opSt:  expMem[x[7:0]] = y;
        opSkip: begin
          result = aluRef(x, y, word[2:0]);
          if ((result == 16'd0 && rd[0]) || (result[15] && rd[1]) ||
              (result != 16'd0 && !result[15] && rd[2])) begin
            regs[pcIndex] = regs[pcIndex] + 16'd1;
          end
        end
        opHalt: return count;
        default: ;
      endcase
    end
    return -1;
  endfunction

  function automatic logic [15:0] regOp(input opcode_t op, input logic [2:0] rd,
                                        input logic [2:0] rs0, input logic [2:0] rs1,
                                        input aluFunc_t fn);
    return {op, rd, rs0, rs1, fn};
  endfunction

  function automatic logic [15:0] ldiOp(input logic [2:0] rd, input logic [8:0] imm);
    return {opLdi, rd, imm};
  endfunction

  // Unused words decode as halt and carry their own address
  task automatic newProgram();
    for (int a = 0; a < 256; a++) begin
      image[a] = {8'hF0, 8'(a)};
    end
    progPc = 0;
  endtask

  task automatic emit(input logic [15:0] word);
    image[progPc] = word;
    progPc++;
  endtask

  task automatic runTest(input string name);
    int count;
    count = isaRun();
    if (count < 0) begin
      failRun({"The reference model never reached a halt in ", name});
    end else begin
      cycleLimit = cycleLimit + count * 4;
      @(negedge clk);
      resetReq = 1'b1;
      wait (reset);
      resetReq = 1'b0;
      loadMem = 1'b1;
      @(negedge clk);
      loadMem = 1'b0;
      wait (!reset);
      wait (halted);
      @(negedge clk);
      @(negedge clk);
      testName = name;
      compareReq = 1'b1;
      wait (compareDone);
      compareReq = 1'b0;
      wait (!compareDone);
    end
  endtask

  // Result region is 0xC0 to 0xFF
  initial begin
    compareDone = 1'b0;
    forever begin
      wait (compareReq);
      for (int a = 192; a < 256; a++) begin
        checkValue($sformatf("%s word %02h", testName, a), expMem[a], mem[a]);
      end
      compareDone = 1'b1;
      wait (!compareReq);
      compareDone = 1'b0;
    end
  end

  task automatic aluOpsTest();
    newProgram();
    image[128] = randomBits(16);
    image[129] = randomBits(16);
    emit(ldiOp(3'd0, 9'd1));
    emit(ldiOp(3'd1, 9'h080));
    emit(ldiOp(3'd2, 9'h081));
    emit(ldiOp(3'd5, 9'h0C0));
    emit(regOp(opLd, 3'd3, 3'd1, 3'd0, aluAdd));
    emit(regOp(opLd, 3'd4, 3'd2, 3'd0, aluAdd));
    for (int f = 0; f < 8; f++) begin
      emit(regOp(opAlu, 3'd6, 3'd3, 3'd4, aluFunc_t'(f)));
      emit(regOp(opSt, 3'd0, 3'd5, 3'd6, aluAdd));
      emit(regOp(opAlu, 3'd5, 3'd5, 3'd0, aluAdd));
    end
    emit(regOp(opHalt, 3'd0, 3'd0, 3'd0, aluAdd));
    runTest("aluOps");
  endtask

  task automatic loadImmediateTest();
    logic [8:0] imm;
    newProgram();
    emit(ldiOp(3'd0, 9'd1));
    emit(ldiOp(3'd5, 9'h0C0));
    for (int i = 0; i < 10; i++) begin
      case (i)
        0: imm = 9'h000;
        1: imm = 9'h0FF;
        2: imm = 9'h1FF;
        3: imm = 9'h100;
        4: imm = 9'h19C;
        default: imm = 9'(randomBits(9));
      endcase
      emit(ldiOp(3'd6, imm));
      emit(regOp(opSt, 3'd0, 3'd5, 3'd6, aluAdd));
      emit(regOp(opAlu, 3'd5, 3'd5, 3'd0, aluAdd));
    end
    emit(regOp(opHalt, 3'd0, 3'd0, 3'd0, aluAdd));
    runTest("loadImmediate");
  endtask

  task automatic loadStoreTest();
    newProgram();
    for (int i = 0; i < 16; i++) begin
      image[128 + i] = randomBits(16);
    end
    emit(ldiOp(3'd0, 9'd1));
    emit(ldiOp(3'd1, 9'h080));
    emit(ldiOp(3'd2, 9'h0C0));
    for (int i = 0; i < 16; i++) begin
      emit(regOp(opLd, 3'd3, 3'd1, 3'd0, aluAdd));
      emit(regOp(opSt, 3'd0, 3'd2, 3'd3, aluAdd));
      emit(regOp(opAlu, 3'd1, 3'd1, 3'd0, aluAdd));
      emit(regOp(opAlu, 3'd2, 3'd2, 3'd0, aluAdd));
    end
    emit(regOp(opHalt, 3'd0, 3'd0, 3'd0, aluAdd));
    runTest("loadStore");
  endtask

  task automatic conditionalSkipTest();
    newProgram();
    // Zero, negative and positive operands
    image[128] = 16'h0000;
    image[129] = randomBits(16) | 16'h8000;
    image[130] = (randomBits(16) & 16'h7FFF) | 16'h0001;
    emit(ldiOp(3'd0, 9'd1));
    emit(ldiOp(3'd5, 9'h0C0));
    emit(ldiOp(3'd6, 9'h05A));
    for (int i = 0; i < 3; i++) begin
      emit(ldiOp(3'd4, 9'(128 + i)));
      emit(regOp(opLd, 3'(i + 1), 3'd4, 3'd0, aluAdd));
    end
    for (int mask = 0; mask < 8; mask++) begin
      for (int cls = 1; cls <= 3; cls++) begin
        emit(regOp(opSkip, 3'(mask), 3'(cls), 3'(cls), aluOr));
        emit(regOp(opSt, 3'd0, 3'd5, 3'd6, aluAdd));
        emit(regOp(opAlu, 3'd5, 3'd5, 3'd0, aluAdd));
      end
    end
    emit(regOp(opHalt, 3'd0, 3'd0, 3'd0, aluAdd));
    runTest("conditionalSkip");
  endtask

  task automatic jumpAndHaltTest();
    logic [8:0] loopCount;
    newProgram();
    loopCount = 9'(randomBits(4)) + 9'd1;
    emit(ldiOp(3'd0, 9'd1));
    emit(ldiOp(3'd5, 9'h0C0));
    emit(ldiOp(3'd6, 9'h0C1));
    emit(ldiOp(3'd4, 9'd3));
    emit(ldiOp(3'd3, 9'd4));
    // PC reads 6 here, so the jump lands on word 9
    emit(regOp(opAlu, 3'd7, 3'd7, 3'd4, aluAdd));
    emit(regOp(opSt, 3'd0, 3'd6, 3'd0, aluAdd));
    emit(regOp(opSt, 3'd0, 3'd6, 3'd4, aluAdd));
    emit(regOp(opSt, 3'd0, 3'd6, 3'd3, aluAdd));
    emit(ldiOp(3'd1, loopCount));
    emit(ldiOp(3'd2, 9'd0));
    // Loop body at word 11
    emit(regOp(opAlu, 3'd2, 3'd2, 3'd0, aluAdd));
    emit(regOp(opAlu, 3'd1, 3'd1, 3'd0, aluSub));
    emit(regOp(opSkip, 3'b001, 3'd1, 3'd1, aluOr));
    // PC reads 15, back by 4
    emit(regOp(opAlu, 3'd7, 3'd7, 3'd3, aluSub));
    emit(regOp(opSt, 3'd0, 3'd5, 3'd2, aluAdd));
    emit(regOp(opHalt, 3'd0, 3'd0, 3'd0, aluAdd));
    runTest("jumpAndHalt");
  endtask

  initial begin
    resetReq = 1'b0;
    loadMem = 1'b0;
    compareReq = 1'b0;
    // Slack for the resets between tests
    cycleLimit = 50;
    wait (!reset);
    for (int round = 0; round < 3; round++) begin
      aluOpsTest();
    end
    loadImmediateTest();
    loadStoreTest();
    conditionalSkipTest();
    jumpAndHaltTest();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  input  logic resetReq,
  output logic clk,
  output logic reset
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Four rising edges in reset, released on a falling edge
  initial begin
    reset = 1'b1;
    forever begin
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(posedge resetReq);
      reset = 1'b1;
    end
  end

endmodule

// File: logic/cpu.sv
`timescale 1ns/1ps

module cpu
  import isaPkg::*, ctrlPkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  output memReq_t              memReq,
  input  logic [dataWidth-1:0] rdata,
  output logic                 halted
);

  ctrl_t                  ctrl;
  instr_t                 ir;
  logic [dataWidth-1:0]   mdr;
  logic [dataWidth-1:0]   mdrNext;
  logic [dataWidth-1:0]   mar;
  logic [dataWidth-1:0]   r0;
  logic [dataWidth-1:0]   r1;
  logic [dataWidth-1:0]   op0;
  logic [dataWidth-1:0]   op1;
  logic [dataWidth-1:0]   aluResult;
  logic [dataWidth-1:0]   regWData;
  logic [regIdxWidth-1:0] rSel0;
  logic                   resultZero;
  logic                   resultNeg;
  logic                   resultPos;
  logic                   skip;

  function automatic logic [dataWidth-1:0] pickOperand(
    input opSel_t               sel,
    input logic [dataWidth-1:0] port0,
    input logic [dataWidth-1:0] port1,
    input logic [dataWidth-1:0] mdrValue
  );
    case (sel)
      selR1:  return port1;
      selMdr: return mdrValue;
      // selPc arrives on port 0 as well
      default: return port0;
    endcase
  endfunction

  decoder decoder0 (
    .clk    (clk),
    .reset  (reset),
    .instr  (ir),
    .ctrl   (ctrl),
    .halted (halted)
  );

  // Port 0 is steered to the PC when either operand asks for it
  assign rSel0 = (ctrl.op0Sel == selPc || ctrl.op1Sel == selPc) ?
                 regIdxWidth'(pcIndex) : ctrl.regR0Sel;

  // Loads take memory data directly in sMem
  assign regWData = ctrl.addrFromMar ? rdata : aluResult;

  regfile regfile0 (
    .clk    (clk),
    .reset  (reset),
    .rSel0  (rSel0),
    .rSel1  (ctrl.regR1Sel),
    .wSel   (ctrl.regWSel),
    .we     (ctrl.regLoad),
    .incrPc (ctrl.incrPc | skip),
    .r0     (r0),
    .r1     (r1),
    .w      (regWData)
  );

  assign op0 = pickOperand(ctrl.op0Sel, r0, r1, mdr);
  assign op1 = pickOperand(ctrl.op1Sel, r0, r1, mdr);

  alu alu0 (
    .x      (op0),
    .y      (op1),
    .func   (ctrl.aluFunc),
    .result (aluResult)
  );

  always_comb begin
    case (ctrl.mdrSel)
      mdrRam:  mdrNext = rdata;
      mdrAlu:  mdrNext = aluResult;
      default: mdrNext = ctrl.imm;
    endcase
  end

  // IR is reset so decode fields are clean before the first fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= '0;
    end else if (ctrl.irLoad) begin
      ir <= rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.mdrLoad) begin
      mdr <= mdrNext;
    end
    if (ctrl.marLoad) begin
      mar <= aluResult;
    end
  end

  // Sign taken from the top bit
  assign resultZero = (aluResult == '0);
  assign resultNeg  = aluResult[dataWidth-1];
  assign resultPos  = !resultZero && !resultNeg;

  assign skip = ctrl.condCheck &&
                ((resultZero && ctrl.skipMask.zero) ||
                 (resultNeg && ctrl.skipMask.negative) ||
                 (resultPos && ctrl.skipMask.positive));

  assign memReq.addr  = ctrl.addrFromMar ? mar : r0;
  assign memReq.wdata = r1;
  assign memReq.write = ctrl.ramWrite;

  // Once halted, the core must leave memory alone
  assert property (@(posedge clk) disable iff (reset) halted |-> !memReq.write);

endmodule

// File: logic/decoder.sv
`timescale 1ns/1ps

module decoder
  import isaPkg::*, ctrlPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  instr_t instr,
  output ctrl_t  ctrl,
  output logic   halted
);

  state_t               state;
  state_t               stateNext;
  opcode_t              opcode;
  logic [dataWidth-1:0] immExt;

  // Both forms share the opcode bits
  assign opcode = instr.regForm.opcode;

  assign immExt = {{(dataWidth - immWidth){instr.immForm.imm[immWidth-1]}},
                   instr.immForm.imm};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sFetch;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      sFetch: stateNext = sDecode;
      sDecode: begin
        if (opcode == opHalt) begin
          stateNext = sHalt;
        end else begin
          stateNext = sExec;
        end
      end
      sExec: begin
        if (opcode == opLd || opcode == opSt) begin
          stateNext = sMem;
        end else begin
          stateNext = sFetch;
        end
      end
      sMem: stateNext = sFetch;
      // Only reset leaves here
      sHalt: stateNext = sHalt;
      default: stateNext = sFetch;
    endcase
  end

  always_comb begin
    ctrl          = '0;
    // Field defaults straight from the register form
    ctrl.aluFunc  = instr.regForm.func;
    ctrl.regR0Sel = instr.regForm.rs0;
    ctrl.regR1Sel = instr.regForm.rs1;
    ctrl.regWSel  = instr.regForm.rd;
    ctrl.skipMask = instr.regForm.rd;
    ctrl.imm      = immExt;
    ctrl.op0Sel   = selR0;
    ctrl.op1Sel   = selR1;
    ctrl.mdrSel   = mdrImm;

    case (state)
      sFetch: begin
        // PC drives the memory address through port 0
        ctrl.irLoad = 1'b1;
        ctrl.op0Sel = selPc;
      end
      sDecode: begin
        ctrl.incrPc = 1'b1;
        if (opcode == opLdi) begin
          ctrl.mdrLoad = 1'b1;
          ctrl.mdrSel  = mdrImm;
        end
      end
      sExec: begin
        case (opcode)
          opAlu: ctrl.regLoad = 1'b1;
          opLdi: begin
            // MDR or MDR passes the immediate unchanged
            ctrl.op0Sel  = selMdr;
            ctrl.op1Sel  = selMdr;
            ctrl.aluFunc = aluOr;
            ctrl.regWSel = instr.immForm.rd;
            ctrl.regLoad = 1'b1;
          end
          opLd, opSt: begin
            ctrl.op1Sel  = selR0;
            ctrl.aluFunc = aluOr;
            ctrl.marLoad = 1'b1;
          end
          opSkip: ctrl.condCheck = 1'b1;
          default: ;
        endcase
      end
      sMem: begin
        ctrl.addrFromMar = 1'b1;
        if (opcode == opLd) begin
          ctrl.regLoad = 1'b1;
        end
        if (opcode == opSt) begin
          ctrl.ramWrite = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign halted = (state == sHalt);

  // Stores only ever follow the MAR load of the previous cycle
  assert property (@(posedge clk) disable iff (reset)
    ctrl.ramWrite |-> (state == sMem) && ($past(state) == sExec));

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile
  import isaPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [regIdxWidth-1:0] rSel0,
  input  logic [regIdxWidth-1:0] rSel1,
  input  logic [regIdxWidth-1:0] wSel,
  input  logic                   we,
  input  logic                   incrPc,
  output logic [dataWidth-1:0]   r0,
  output logic [dataWidth-1:0]   r1,
  input  logic [dataWidth-1:0]   w
);

  logic [dataWidth-1:0] regs [numRegs];
  logic                 pcWritten;

  assign r0 = regs[rSel0];
  assign r1 = regs[rSel1];

  // A jump beats the increment
  assign pcWritten = we && (wSel == regIdxWidth'(pcIndex));

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (incrPc && !pcWritten) begin
        regs[pcIndex] <= regs[pcIndex] + dataWidth'(1);
      end
      if (we) begin
        regs[wSel] <= w;
      end
    end
  end

  // The write enable comes from the decoder state
  assert property (@(posedge clk) disable iff (reset) !$isunknown(we));

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu
  import isaPkg::*;
(
  input  logic [dataWidth-1:0] x,
  input  logic [dataWidth-1:0] y,
  input  aluFunc_t             func,
  output logic [dataWidth-1:0] result
);

  always_comb begin
    case (func)
      aluAdd: result = x + y;
      aluSub: result = x - y;
      aluAnd: result = x & y;
      aluOr:  result = x | y;
      aluXor: result = x ^ y;
      // Single operand functions ignore y
      aluNot: result = ~x;
      aluShl: result = {x[dataWidth-2:0], 1'b0};
      aluShr: result = {1'b0, x[dataWidth-1:1]};
      default: result = '0;
    endcase
  end

endmodule

// File: logic/ctrlPkg.sv
package ctrlPkg;

  import isaPkg::*;

  typedef enum logic [3:0] {
    sFetch,
    sDecode,
    sExec,
    sMem,
    sHalt
  } state_t;

  // selPc reads register 7 through read port 0
  typedef enum logic [1:0] {
    selR0  = 2'd0,
    selR1  = 2'd1,
    selMdr = 2'd2,
    selPc  = 2'd3
  } opSel_t;

  typedef enum logic [1:0] {
    mdrImm = 2'd0,
    mdrRam = 2'd1,
    mdrAlu = 2'd2
  } mdrSel_t;

  // Everything the datapath needs for one cycle
  typedef struct packed {
    logic                   irLoad;
    logic                   mdrLoad;
    logic                   marLoad;
    logic                   regLoad;
    logic                   ramWrite;
    logic                   incrPc;
    logic                   condCheck;
    opSel_t                 op0Sel;
    opSel_t                 op1Sel;
    mdrSel_t                mdrSel;
    logic                   addrFromMar;
    aluFunc_t               aluFunc;
    logic [regIdxWidth-1:0] regR0Sel;
    logic [regIdxWidth-1:0] regR1Sel;
    logic [regIdxWidth-1:0] regWSel;
    skipMask_t              skipMask;
    logic [dataWidth-1:0]   imm;
  } ctrl_t;

  typedef struct packed {
    logic [dataWidth-1:0] addr;
    logic [dataWidth-1:0] wdata;
    logic                 write;
  } memReq_t;

endpackage

// File: logic/isaPkg.sv
package isaPkg;

  // Machine word and register file geometry
  localparam int dataWidth   = 16;
  localparam int numRegs     = 8;
  localparam int regIdxWidth = $clog2(numRegs);
  // Register 7 doubles as the program counter
  localparam int pcIndex     = 7;
  // Immediate field of the Ldi form
  localparam int immWidth    = 9;

  typedef enum logic [3:0] {
    opAlu  = 4'd0,
    opLdi  = 4'd1,
    opLd   = 4'd2,
    opSt   = 4'd3,
    opSkip = 4'd4,
    opHalt = 4'd15
  } opcode_t;

  // Shifts are by one position, not takes only x
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluXor = 3'd4,
    aluNot = 3'd5,
    aluShl = 3'd6,
    aluShr = 3'd7
  } aluFunc_t;

  typedef struct packed {
    opcode_t                opcode;
    logic [regIdxWidth-1:0] rd;
    logic [regIdxWidth-1:0] rs0;
    logic [regIdxWidth-1:0] rs1;
    aluFunc_t               func;
  } regForm_t;

  typedef struct packed {
    opcode_t                opcode;
    logic [regIdxWidth-1:0] rd;
    logic [immWidth-1:0]    imm;
  } immForm_t;

  // Ldi reads the immediate form, every other opcode the register form
  typedef union packed {
    regForm_t regForm;
    immForm_t immForm;
  } instr_t;

  // Lives in the rd field of a skip
  typedef struct packed {
    logic positive;
    logic negative;
    logic zero;
  } skipMask_t;

endpackage
